//--- all.f
+incdir+tests
hdl/opn_regmap_pkg.sv
hdl/opn_bus_pkg.sv
hdl/opn_host_port.sv
hdl/opn_prescaler.sv
hdl/opn_busy_fsm.sv
hdl/opn_global_regs.sv
hdl/opn_ch3_freq.sv
hdl/opn_update_decode.sv
hdl/opn_mmr.sv
tests/opn_mmr_tb.sv

//--- hdl/opn_bus_pkg.sv
/*
 * OPN grouped signals
 * Packed structs for the host write, the global register outputs, the
 * channel-3 frequencies and the update strobes, plus the busy FSM states
 */
package opn_bus_pkg;

    // Current data write with its latched select
    typedef struct packed {
        logic                      valid;
        logic                      part;   // Bank
        opn_regmap_pkg::reg_addr_t addr;
        opn_regmap_pkg::reg_data_t data;
    } reg_write_t;

    typedef struct packed {
        opn_regmap_pkg::timer_a_t value_a;
        opn_regmap_pkg::timer_b_t value_b;
        logic                     load_a;
        logic                     load_b;
        logic                     irq_en_a;
        logic                     irq_en_b;
        logic                     clr_flag_a;  // One-shot
        logic                     clr_flag_b;  // One-shot
        logic                     fast;
    } timer_ctl_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } lfo_cfg_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
    } test_cfg_t;

    typedef struct packed {
        opn_regmap_pkg::pcm_t sample;
        logic                 en;
        logic                 wr;      // One-shot
    } pcm_out_t;

    typedef struct packed {
        opn_regmap_pkg::block_t op1_block;
        opn_regmap_pkg::fnum_t  op1_fnum;
        opn_regmap_pkg::block_t op2_block;
        opn_regmap_pkg::fnum_t  op2_fnum;
        opn_regmap_pkg::block_t op3_block;
        opn_regmap_pkg::fnum_t  op3_fnum;
    } ch3_freq_t;

    // Strobes for the per-channel register file
    typedef struct packed {
        logic                      keyon;
        logic [2:0]                chreg;  // fnumlo, alg, pms from bit 0
        logic [6:0]                opreg;  // dt1 up to ssgeg from bit 0
        logic [2:0]                ch;     // Part and channel
        logic [1:0]                op;
        opn_regmap_pkg::reg_data_t data;
    } chan_update_t;

    typedef enum logic {
        IDLE,
        BUSY
    } busy_state_e;

endpackage

//--- hdl/opn_busy_fsm.sv
/*
 * OPN busy flag
 * Raises busy after each data write and drops it once the set number of
 * clock-enable ticks has passed; a new write restarts the count
 */
`timescale 1ns/1ps

module opn_busy_fsm (
    input  logic clk,
    input  logic rst,
    input  logic clk_en,
    input  logic data_start,
    output logic busy
);

    opn_bus_pkg::busy_state_e  state;
    opn_regmap_pkg::busy_cnt_t ticks;
    opn_regmap_pkg::busy_cnt_t ticks_next;

    assign ticks_next = ticks + 6'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= opn_bus_pkg::IDLE;
            ticks <= '0;
        end else if (data_start) begin
            // Restart, also while already busy
            state <= opn_bus_pkg::BUSY;
            ticks <= '0;
        end else begin
            case (state)
                opn_bus_pkg::BUSY: begin
                    if (clk_en) begin
                        if (ticks_next == opn_regmap_pkg::BUSY_TICKS) begin
                            state <= opn_bus_pkg::IDLE;
                            ticks <= '0;
                        end else begin
                            ticks <= ticks_next;
                        end
                    end
                end
                default: begin
                    ticks <= '0;  // Idle keeps the count parked
                end
            endcase
        end
    end

    assign busy = (state == opn_bus_pkg::BUSY);

endmodule

//--- hdl/opn_ch3_freq.sv
/*
 * OPN channel-3 frequencies
 * Per-operator block and fnum for channel-3 special mode, loaded through
 * the frequency-high latch shared by all channels
 */
`timescale 1ns/1ps

module opn_ch3_freq (
    input  logic                    clk,
    input  logic                    rst,
    input  opn_bus_pkg::reg_write_t wr,
    output opn_bus_pkg::ch3_freq_t  ch3
);

    opn_regmap_pkg::fnum_hi_t fnum_hi;  // Block and fnum[10:8]

    // Both banks reach the latch
    always_ff @(posedge clk) begin
        if (rst) begin
            fnum_hi <= '0;
            ch3     <= '0;
        end else if (wr.valid) begin
            case (wr.addr)
                8'hA4, 8'hA5, 8'hA6,
                8'hAC, 8'hAD, 8'hAE: fnum_hi <= wr.data[5:0];
                opn_regmap_pkg::REG_CH3_OP1: begin
                    {ch3.op1_block, ch3.op1_fnum} <= {fnum_hi, wr.data};
                end
                opn_regmap_pkg::REG_CH3_OP2: begin
                    {ch3.op2_block, ch3.op2_fnum} <= {fnum_hi, wr.data};
                end
                opn_regmap_pkg::REG_CH3_OP3: begin
                    {ch3.op3_block, ch3.op3_fnum} <= {fnum_hi, wr.data};
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/opn_global_regs.sv
/*
 * OPN global registers
 * Bank-0 test, LFO, timer, timer control and DAC registers. The timer
 * flag clears and the PCM write pulse drop on the next idle clock enable
 */
`timescale 1ns/1ps

module opn_global_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clk_en,
    input  opn_bus_pkg::reg_write_t  wr,
    output opn_bus_pkg::timer_ctl_t  timer,
    output opn_bus_pkg::lfo_cfg_t    lfo,
    output opn_bus_pkg::test_cfg_t   test,
    output opn_bus_pkg::pcm_out_t    pcm,
    output logic                     ch3_effect
);

    logic bank0_wr;

    assign bank0_wr = wr.valid && !wr.part;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer      <= '0;
            lfo        <= '0;
            test       <= '0;
            pcm        <= '0;
            ch3_effect <= 1'b0;
        end else if (wr.valid) begin
            if (bank0_wr) begin
                case (wr.addr)
                    opn_regmap_pkg::REG_TEST: begin
                        test.eg_stop <= wr.data[5];
                        test.pg_stop <= wr.data[3];
                        timer.fast   <= wr.data[2];
                    end
                    opn_regmap_pkg::REG_LFO: begin
                        lfo.en   <= wr.data[3];
                        lfo.freq <= wr.data[2:0];
                    end
                    opn_regmap_pkg::REG_CLKA1: timer.value_a[9:2] <= wr.data;
                    opn_regmap_pkg::REG_CLKA2: timer.value_a[1:0] <= wr.data[1:0];
                    opn_regmap_pkg::REG_CLKB:  timer.value_b      <= wr.data;
                    opn_regmap_pkg::REG_TIMER: begin
                        ch3_effect       <= |wr.data[7:6];  // Any special mode
                        timer.clr_flag_b <= wr.data[5];
                        timer.clr_flag_a <= wr.data[4];
                        timer.irq_en_b   <= wr.data[3];
                        timer.irq_en_a   <= wr.data[2];
                        timer.load_b     <= wr.data[1];
                        timer.load_a     <= wr.data[0];
                    end
                    opn_regmap_pkg::REG_PCM: begin
                        // Offset binary to the DAC, LSB forced high
                        pcm.sample <= {~wr.data[7], wr.data[6:0], 1'b1};
                    end
                    opn_regmap_pkg::REG_PCM_EN:  pcm.en        <= wr.data[7];
                    opn_regmap_pkg::REG_DACTEST: pcm.sample[0] <= wr.data[3];
                    default: ;
                endcase
            end
            // Any other data write ends the pulse
            pcm.wr <= bank0_wr && (wr.addr == opn_regmap_pkg::REG_PCM);
        end else if (clk_en) begin
            timer.clr_flag_a <= 1'b0;
            timer.clr_flag_b <= 1'b0;
            pcm.wr           <= 1'b0;
        end
    end

endmodule

//--- hdl/opn_host_port.sv
/*
 * OPN host port
 * Keeps the register number and bank chosen by address writes and
 * presents each data write together with that selection
 */
`timescale 1ns/1ps

module opn_host_port (
    input  logic                       clk,
    input  logic                       rst,
    input  opn_regmap_pkg::reg_data_t  din,
    input  logic [1:0]                 addr,
    input  logic                       write,
    output opn_bus_pkg::reg_write_t    wr,
    output logic                       data_start
);

    opn_regmap_pkg::reg_addr_t sel_addr;
    logic                      sel_part;
    logic                      old_write;

    // Select latch
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_addr <= '0;
            sel_part <= 1'b0;
        end else if (write && !addr[0]) begin
            sel_addr <= din;
            sel_part <= addr[1];  // Bank comes from the address write
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
        end else begin
            old_write <= write;
        end
    end

    // Data write as seen by the register blocks
    always_comb begin
        wr.valid = write && addr[0];
        wr.part  = sel_part;
        wr.addr  = sel_addr;
        wr.data  = din;
    end

    assign data_start = write && !old_write && addr[0];  // Rising edge only

endmodule

//--- hdl/opn_mmr.sv
/*
 * OPN host register interface
 * Top level: host port, prescaler, busy flag, global registers,
 * channel-3 frequencies and the update strobe decode
 */
`timescale 1ns/1ps

module opn_mmr (
    input  logic                      clk,
    input  logic                      rst,
    input  opn_regmap_pkg::reg_data_t din,
    input  logic [1:0]                addr,
    input  logic                      write,
    output logic                      clk_en,
    output logic                      busy,
    output opn_bus_pkg::timer_ctl_t   timer,
    output opn_bus_pkg::lfo_cfg_t     lfo,
    output opn_bus_pkg::test_cfg_t    test,
    output opn_bus_pkg::pcm_out_t     pcm,
    output logic                      ch3_effect,
    output opn_bus_pkg::ch3_freq_t    ch3,
    output opn_bus_pkg::chan_update_t update
);

    opn_bus_pkg::reg_write_t wr;          // Current data write
    logic                    data_start;

    opn_host_port host_port_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .addr       (addr),
        .write      (write),
        .wr         (wr),
        .data_start (data_start)
    );

    opn_prescaler prescaler_inst (
        .clk    (clk),
        .rst    (rst),
        .write  (write),
        .addr   (addr),
        .din    (din),
        .clk_en (clk_en)
    );

    opn_busy_fsm busy_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .data_start (data_start),
        .busy       (busy)
    );

    opn_global_regs global_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .wr         (wr),
        .timer      (timer),
        .lfo        (lfo),
        .test       (test),
        .pcm        (pcm),
        .ch3_effect (ch3_effect)
    );

    opn_ch3_freq ch3_freq_inst (
        .clk (clk),
        .rst (rst),
        .wr  (wr),
        .ch3 (ch3)
    );

    opn_update_decode update_decode_inst (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr),
        .update (update)
    );

endmodule

//--- hdl/opn_prescaler.sv
/*
 * OPN prescaler
 * Picks the divide ratio from address writes to 2D, 2E and 2F and
 * produces a one-cycle clock enable every N clocks
 */
`timescale 1ns/1ps

module opn_prescaler (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write,
    input  logic [1:0]                addr,
    input  opn_regmap_pkg::reg_data_t din,
    output logic                      clk_en
);

    opn_regmap_pkg::div_sel_t div_sel;
    opn_regmap_pkg::div_cnt_t cnt;
    opn_regmap_pkg::div_cnt_t ratio;

    // Selecting the register is enough, no data write needed
    always_ff @(posedge clk) begin
        if (rst) begin
            div_sel <= opn_regmap_pkg::DIV_SEL_RESET;
        end else if (write && !addr[0]) begin
            case (din)
                opn_regmap_pkg::REG_CLK_N6: div_sel[1] <= 1'b1;
                opn_regmap_pkg::REG_CLK_N3: div_sel[0] <= 1'b1;
                opn_regmap_pkg::REG_CLK_N2: div_sel    <= 2'b00;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (div_sel)
            2'b10:   ratio = opn_regmap_pkg::DIV_RATIO_6;
            2'b00:   ratio = opn_regmap_pkg::DIV_RATIO_2;
            default: ratio = opn_regmap_pkg::DIV_RATIO_3;  // 01 and 11
        endcase
    end

    // >= also covers a ratio that shrinks mid-count
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt >= ratio - 3'd1) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    assign clk_en = (cnt == '0);

endmodule

//--- hdl/opn_regmap_pkg.sv
/*
 * OPN register map
 * Register numbers, field widths and prescaler constants for the host
 * register interface of the six-channel FM synthesis chip
 */
package opn_regmap_pkg;

    typedef logic [7:0]  reg_addr_t;   // Register number
    typedef logic [7:0]  reg_data_t;   // Host data word
    typedef logic [10:0] fnum_t;       // Frequency number
    typedef logic [2:0]  block_t;      // Octave block
    typedef logic [5:0]  fnum_hi_t;    // Block plus fnum[10:8]
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;
    typedef logic [8:0]  pcm_t;        // DAC sample
    typedef logic [1:0]  div_sel_t;    // Prescaler select
    typedef logic [2:0]  div_cnt_t;    // Prescaler counter
    typedef logic [5:0]  busy_cnt_t;   // Busy tick counter

    // Bank-0 global registers
    localparam reg_addr_t REG_TEST    = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;

    // Prescaler select, acts on the address write alone
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

    // Channel-3 special mode, operators 1 to 3
    localparam reg_addr_t REG_CH3_OP1 = 8'hA9;
    localparam reg_addr_t REG_CH3_OP2 = 8'hAA;
    localparam reg_addr_t REG_CH3_OP3 = 8'hA8;

    localparam div_sel_t DIV_SEL_RESET = 2'b10;  // Divide by 6
    localparam div_cnt_t DIV_RATIO_6   = 3'd6;
    localparam div_cnt_t DIV_RATIO_3   = 3'd3;
    localparam div_cnt_t DIV_RATIO_2   = 3'd2;

    localparam busy_cnt_t BUSY_TICKS = 6'd32;    // clk_en ticks per data write

endpackage

//--- hdl/opn_update_decode.sv
/*
 * OPN update decode
 * Turns channel and operator register writes into one-cycle one-hot
 * strobes with channel, operator and data for the register file
 */
`timescale 1ns/1ps

module opn_update_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  opn_bus_pkg::reg_write_t   wr,
    output opn_bus_pkg::chan_update_t update
);

    always_ff @(posedge clk) begin
        if (rst) begin
            update <= '0;
        end else begin
            update <= '0;  // Strobes last one cycle
            if (wr.valid) begin
                update.keyon <= !wr.part && (wr.addr == opn_regmap_pkg::REG_KON);
                update.ch    <= {wr.part, wr.addr[1:0]};
                update.op    <= wr.addr[3:2];
                update.data  <= wr.data;
                // Channel slot 3 does not exist
                if (wr.addr[1:0] != 2'b11) begin
                    casez (wr.addr)
                        8'hA0, 8'hA1, 8'hA2: update.chreg <= 3'b001;  // fnumlo
                        8'hB0, 8'hB1, 8'hB2: update.chreg <= 3'b010;  // alg
                        8'hB4, 8'hB5, 8'hB6: update.chreg <= 3'b100;  // pms
                        8'h3?: update.opreg <= 7'h01;  // dt1
                        8'h4?: update.opreg <= 7'h02;  // tl
                        8'h5?: update.opreg <= 7'h04;  // ks_ar
                        8'h6?: update.opreg <= 7'h08;  // amen_dr
                        8'h7?: update.opreg <= 7'h10;  // sr
                        8'h8?: update.opreg <= 7'h20;  // sl_rr
                        8'h9?: update.opreg <= 7'h40;  // ssgeg
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

//--- tests/opn_mmr_model.svh
/*
 * OPN register interface reference model
 * Expected register state, strobes and prescaler select, updated for
 * each host address and data write
 */
`ifndef OPN_MMR_MODEL_SVH
`define OPN_MMR_MODEL_SVH

opn_bus_pkg::timer_ctl_t   exp_timer;
opn_bus_pkg::lfo_cfg_t     exp_lfo;
opn_bus_pkg::test_cfg_t    exp_test;
opn_bus_pkg::pcm_out_t     exp_pcm;
logic                      exp_ch3_effect;
opn_bus_pkg::ch3_freq_t    exp_ch3;
opn_bus_pkg::chan_update_t exp_update;   // Strobes seen one cycle after a write
opn_regmap_pkg::fnum_hi_t  exp_fnum_hi;  // Shared frequency-high latch
opn_regmap_pkg::div_sel_t  exp_div_sel;

task automatic model_reset();
    exp_timer      = '0;
    exp_lfo        = '0;
    exp_test       = '0;
    exp_pcm        = '0;
    exp_ch3_effect = 1'b0;
    exp_ch3        = '0;
    exp_update     = '0;
    exp_fnum_hi    = '0;
    exp_div_sel    = 2'b10;
endtask

// Prescaler select reacts to the register number alone
task automatic model_address_write(input opn_regmap_pkg::reg_addr_t num);
    if (num == 8'h2D) begin
        exp_div_sel[1] = 1'b1;
    end else if (num == 8'h2E) begin
        exp_div_sel[0] = 1'b1;
    end else if (num == 8'h2F) begin
        exp_div_sel = 2'b00;
    end
endtask

task automatic model_data_write(input logic part, input opn_regmap_pkg::reg_addr_t num,
                                input opn_regmap_pkg::reg_data_t data);
    exp_update       = '0;
    exp_update.keyon = !part && (num == 8'h28);
    exp_update.ch    = {part, num[1:0]};
    exp_update.op    = num[3:2];
    exp_update.data  = data;
    if (num[1:0] != 2'b11) begin
        if (num[7:4] == 4'hA && num[3:2] == 2'b00) begin
            exp_update.chreg = 3'b001;
        end else if (num[7:4] == 4'hB && num[3:2] == 2'b00) begin
            exp_update.chreg = 3'b010;
        end else if (num[7:4] == 4'hB && num[3:2] == 2'b01) begin
            exp_update.chreg = 3'b100;
        end else if (num[7:4] >= 4'h3 && num[7:4] <= 4'h9) begin
            exp_update.opreg = 7'b1 << (num[7:4] - 4'h3);  // 3x is dt1
        end
    end
    // Latch and channel-3 operators in either bank
    if (num[7:4] == 4'hA && num[2] && num[1:0] != 2'b11) begin
        exp_fnum_hi = data[5:0];
    end else if (num == 8'hA9) begin
        {exp_ch3.op1_block, exp_ch3.op1_fnum} = {exp_fnum_hi, data};
    end else if (num == 8'hAA) begin
        {exp_ch3.op2_block, exp_ch3.op2_fnum} = {exp_fnum_hi, data};
    end else if (num == 8'hA8) begin
        {exp_ch3.op3_block, exp_ch3.op3_fnum} = {exp_fnum_hi, data};
    end
    exp_pcm.wr = !part && (num == 8'h2A);
    if (!part) begin
        case (num)
            8'h21: begin
                exp_test.eg_stop = data[5];
                exp_test.pg_stop = data[3];
                exp_timer.fast   = data[2];
            end
            8'h22: begin
                exp_lfo.en   = data[3];
                exp_lfo.freq = data[2:0];
            end
            8'h24: exp_timer.value_a[9:2] = data;
            8'h25: exp_timer.value_a[1:0] = data[1:0];
            8'h26: exp_timer.value_b = data;
            8'h27: begin
                exp_ch3_effect      = (data[7:6] != 2'b00);
                exp_timer.clr_flag_b = data[5];
                exp_timer.clr_flag_a = data[4];
                exp_timer.irq_en_b   = data[3];
                exp_timer.irq_en_a   = data[2];
                exp_timer.load_b     = data[1];
                exp_timer.load_a     = data[0];
            end
            8'h2A: exp_pcm.sample = {~data[7], data[6:0], 1'b1};
            8'h2B: exp_pcm.en = data[7];
            8'h2C: exp_pcm.sample[0] = data[3];
            default: ;
        endcase
    end
endtask

// Idle clock enables have passed since the write
task automatic model_clear_one_shots();
    exp_timer.clr_flag_a = 1'b0;
    exp_timer.clr_flag_b = 1'b0;
    exp_pcm.wr           = 1'b0;
    exp_update           = '0;
endtask

function automatic int expected_period(input opn_regmap_pkg::div_sel_t sel);
    case (sel)
        2'b10:   return 6;
        2'b00:   return 2;
        default: return 3;
    endcase
endfunction

`endif

//--- tests/opn_mmr_tb.sv
/*
 * OPN register interface testbench
 * Random host writes through every register group, checked against the
 * reference model, with busy and clock-enable timing checks
 */
`timescale 1ns/1ps

module opn_mmr_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int GLOBAL_WRITES  = 48;
    localparam int PCM_WRITES     = 24;
    localparam int CH3_PAIRS      = 24;
    localparam int UPDATE_WRITES  = 64;
    localparam int PRESCALE_STEPS = 5;
    localparam int DATA_WRITES    = GLOBAL_WRITES + PCM_WRITES + 2 * CH3_PAIRS
                                    + UPDATE_WRITES + 2 * PRESCALE_STEPS;
    // Address plus data access per write
    localparam int TOTAL_ACCESSES = 2 * DATA_WRITES + PRESCALE_STEPS + RESET_CYCLES;
    localparam int WORST_CYCLES   = 32 * 6 + 4;
    localparam longint TIMEOUT_NS = longint'(TOTAL_ACCESSES) * WORST_CYCLES * CLK_PERIOD * 2;
    localparam int BUSY_LIMIT     = WORST_CYCLES + 8;
    localparam int EXPECTED_TICKS = 32;

    logic                      clk;
    logic                      rst;
    opn_regmap_pkg::reg_data_t din;
    logic [1:0]                addr;
    logic                      write;
    logic                      clk_en;
    logic                      busy;
    opn_bus_pkg::timer_ctl_t   timer;
    opn_bus_pkg::lfo_cfg_t     lfo;
    opn_bus_pkg::test_cfg_t    test;
    opn_bus_pkg::pcm_out_t     pcm;
    logic                      ch3_effect;
    opn_bus_pkg::ch3_freq_t    ch3;
    opn_bus_pkg::chan_update_t update;

    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed;

    `include "opn_mmr_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    opn_mmr opn_mmr_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .addr       (addr),
        .write      (write),
        .clk_en     (clk_en),
        .busy       (busy),
        .timer      (timer),
        .lfo        (lfo),
        .test       (test),
        .pcm        (pcm),
        .ch3_effect (ch3_effect),
        .ch3        (ch3),
        .update     (update)
    );

    task automatic check_value(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_state(input string name);
        check_value(name, "timer", exp_timer, timer);
        check_value(name, "lfo", exp_lfo, lfo);
        check_value(name, "test", exp_test, test);
        check_value(name, "pcm", exp_pcm, pcm);
        check_value(name, "ch3_effect", exp_ch3_effect, ch3_effect);
        check_value(name, "ch3", exp_ch3, ch3);
        check_value(name, "update", exp_update, update);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic address_write(input logic part, input opn_regmap_pkg::reg_addr_t num);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b0};
        din   <= num;
        @(posedge clk);
        write <= 1'b0;
        model_address_write(num);
    endtask

    // Full access, then follow busy until it drops
    task automatic data_write(input string name, input logic part,
                              input opn_regmap_pkg::reg_addr_t num,
                              input opn_regmap_pkg::reg_data_t data);
        int ticks;
        int cycles;
        address_write(part, num);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b1};
        din   <= data;
        @(posedge clk);
        write <= 1'b0;
        model_data_write(part, num, data);
        @(negedge clk);
        check_value(name, "busy", 1, busy);
        check_state(name);
        ticks  = 0;
        cycles = 0;
        while (busy === 1'b1 && cycles < BUSY_LIMIT) begin
            if (clk_en === 1'b1) ticks++;
            @(negedge clk);
            cycles++;
            if (cycles == 1) check_value(name, "update after strobe", 0, update);
        end
        assert (busy === 1'b0) else begin
            $display("%s: busy stayed high for %0d cycles after a write", name, cycles);
            test_errors++;
        end
        check_value(name, "busy ticks", EXPECTED_TICKS, ticks);
        model_clear_one_shots();
        check_state(name);
    endtask

    // Cycles from one clk_en to the next, sampled on falling edges
    task automatic measure_period(output int period);
        int wait_cycles;
        wait_cycles = 0;
        while (clk_en !== 1'b1 && wait_cycles < 16) begin
            @(negedge clk);
            wait_cycles++;
        end
        @(negedge clk);
        period = 1;
        while (clk_en !== 1'b1 && period < 16) begin
            @(negedge clk);
            period++;
        end
    endtask

    function automatic opn_regmap_pkg::reg_addr_t random_global_reg();
        case ($urandom % 6)
            0:       return 8'h21;
            1:       return 8'h22;
            2:       return 8'h24;
            3:       return 8'h25;
            4:       return 8'h26;
            default: return 8'h27;
        endcase
    endfunction

    function automatic opn_regmap_pkg::reg_addr_t random_ch3_op_reg();
        case ($urandom % 3)
            0:       return 8'hA8;
            1:       return 8'hA9;
            default: return 8'hAA;
        endcase
    endfunction

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int                        period;
        opn_regmap_pkg::reg_addr_t num;
        clk          = 1'b0;
        rst          = 1'b1;
        din          = '0;
        addr         = '0;
        write        = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hb827;
        period       = $urandom(seed);
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("reset", "busy", 0, busy);
        check_state("reset");
        measure_period(period);
        check_value("reset", "clk_en period", 6, period);
        finish_test("reset");

        // Bank 1 copies must leave the outputs alone
        for (int i = 0; i < GLOBAL_WRITES; i++) begin
            data_write("global", i >= 32, random_global_reg(), 8'($urandom));
        end
        finish_test("global");

        for (int i = 0; i < PCM_WRITES; i++) begin
            num = 8'h2A + 8'($urandom % 3);
            data_write("pcm", 1'b0, num, 8'($urandom));
        end
        finish_test("pcm");

        for (int i = 0; i < CH3_PAIRS; i++) begin
            num = 8'hA4 + 8'($urandom % 3) + 8'(($urandom % 2) * 8);
            data_write("ch3_freq", 1'($urandom), num, 8'($urandom));
            data_write("ch3_freq", 1'($urandom), random_ch3_op_reg(), 8'($urandom));
        end
        finish_test("ch3_freq");

        for (int i = 0; i < UPDATE_WRITES; i++) begin
            num = 8'h20 + 8'($urandom % 8'hA0);
            data_write("update", 1'($urandom), num, 8'($urandom));
        end
        finish_test("update");

        // Selects 00, 01, 11, 00, 10 in turn
        for (int i = 0; i < PRESCALE_STEPS; i++) begin
            case (i)
                0, 3:    num = 8'h2F;
                1:       num = 8'h2E;
                default: num = 8'h2D;
            endcase
            address_write(1'b0, num);
            @(negedge clk);
            measure_period(period);  // Let a shrinking ratio settle
            measure_period(period);
            check_value("prescaler", "clk_en period", expected_period(exp_div_sel), period);
            repeat (2) begin
                data_write("prescaler", 1'b1, 8'h30 + 8'($urandom % 8'h70), 8'($urandom));
            end
        end
        finish_test("prescaler");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
